//--- hw/aessub_types_pkg.sv
package aessub_types_pkg;

        // Operand layout
        localparam int NUM_BYTES = 4;                   // Bytes per operand word
        localparam int BYTE_W    = 8;
        localparam int WORD_W    = NUM_BYTES * BYTE_W;

        // Lane and group bookkeeping, up to four of each
        localparam int IDX_W = 2;

        typedef logic [WORD_W-1:0] word_t;              // rs1, rs2 or result
        typedef logic [BYTE_W-1:0] byte_t;              // One S-box value

        typedef logic [IDX_W-1:0] lane_idx_t;           // Byte slot within a word
        typedef logic [IDX_W-1:0] group_idx_t;          // Lane group counter

        // Issue side FSM
        typedef enum logic {
                IDLE,                                   // Waiting for an operation
                ISSUE                                   // Offering groups to the lanes
        } issue_state_t;

        // Collect side FSM
        typedef enum logic {
                FILL,                                   // Draining lane groups
                HOLD                                    // Result waits for consumer
        } collect_state_t;

endpackage

//--- hw/aes_field_pkg.sv
package aes_field_pkg;

        import aessub_types_pkg::*;

        // x^8 + x^4 + x^3 + x + 1, with the x^8 term implied
        localparam byte_t AES_POLY = 8'h1b;

        localparam byte_t AFFINE_CONST     = 8'h63;     // Forward affine offset
        localparam byte_t INV_AFFINE_CONST = 8'h05;     // Inverse affine offset

        function automatic byte_t rotl(input byte_t x, input int n);
                return (x << n) | (x >> (8 - n));
        endfunction

        // Multiply by x, reduced
        function automatic byte_t xtime(input byte_t a);
                return {a[6:0], 1'b0} ^ (a[7] ? AES_POLY : 8'h00);
        endfunction

        function automatic byte_t gf_mul(input byte_t a, input byte_t b);
                byte_t acc;
                byte_t p;
                acc = '0;
                p   = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                acc = acc ^ p;          // Add this partial product
                        p = xtime(p);
                end
                return acc;
        endfunction

        // a^254 is the multiplicative inverse, and maps 0 to 0
        function automatic byte_t gf_inv(input byte_t a);
                byte_t sq;
                byte_t acc;
                sq  = a;
                acc = 8'h01;
                for (int i = 1; i < 8; i++) begin
                        sq  = gf_mul(sq, sq);           // a^(2^i)
                        acc = gf_mul(acc, sq);
                end
                return acc;
        endfunction

        function automatic byte_t affine_fwd(input byte_t x);
                return x ^ rotl(x, 1) ^ rotl(x, 2) ^ rotl(x, 3) ^ rotl(x, 4) ^ AFFINE_CONST;
        endfunction

        function automatic byte_t affine_inv(input byte_t x);
                return rotl(x, 1) ^ rotl(x, 3) ^ rotl(x, 6) ^ INV_AFFINE_CONST;
        endfunction

        function automatic byte_t sbox_fwd(input byte_t x);
                return affine_fwd(gf_inv(x));
        endfunction

        // Undo the affine map first, then invert
        function automatic byte_t sbox_inv(input byte_t x);
                return gf_inv(affine_inv(x));
        endfunction

endpackage

//--- hw/aessub_issue.sv
`timescale 1ns/1ps

module aessub_issue
        import aessub_types_pkg::*;
#(
        parameter int NUM_LANES = 4
) (
        input  logic                      clock,
        input  logic                      rst,
        input  logic                      in_valid,
        output logic                      in_ready,
        input  word_t                     rs1,
        input  word_t                     rs2,
        input  logic                      enc,
        input  logic                      rot,
        output logic                      lane_valid,
        output byte_t [NUM_LANES-1:0]     lane_in,
        output logic                      inv,
        input  logic [NUM_LANES-1:0]      lane_in_ready
);

        localparam int GROUPS = NUM_BYTES / NUM_LANES;

        issue_state_t          state;
        group_idx_t            grp;                     // Group on offer
        byte_t [NUM_BYTES-1:0] gath;                    // Bytes in rs1/rs2 order
        byte_t [NUM_BYTES-1:0] ordered;                 // After optional rotation
        byte_t [NUM_BYTES-1:0] ops;                     // Registered operation bytes
        lane_idx_t             sel [NUM_LANES];
        logic                  all_ready;
        logic                  last_grp;
        logic                  take;

        // Alternate between the two source registers
        assign gath[0] = rs1[7:0];
        assign gath[1] = rs2[15:8];
        assign gath[2] = rs1[23:16];
        assign gath[3] = rs2[31:24];

        // Rotation is a byte permutation, so it can happen ahead of the S-box
        assign ordered = rot ? {gath[2], gath[1], gath[0], gath[3]} : gath;

        assign all_ready  = &lane_in_ready;
        assign last_grp   = (grp == group_idx_t'(GROUPS - 1));
        assign lane_valid = (state == ISSUE);
        assign in_ready   = (state == IDLE) || (lane_valid && all_ready && last_grp);
        assign take       = in_valid && in_ready;

        for (genvar k = 0; k < NUM_LANES; k++) begin : g_sel
                assign sel[k]     = lane_idx_t'(grp * NUM_LANES + k);
                assign lane_in[k] = ops[sel[k]];
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        state <= IDLE;
                        grp   <= '0;
                end else if (take) begin
                        state <= ISSUE;                 // Also covers back-to-back ops
                        grp   <= '0;
                end else if (lane_valid && all_ready) begin
                        if (last_grp)
                                state <= IDLE;
                        else
                                grp <= grp + 1'b1;
                end
        end

        always_ff @(posedge clock) begin
                if (take) begin
                        ops <= ordered;
                        inv <= ~enc;
                end
        end

        // A stalled group must not change under the lanes
        assert property (@(posedge clock) disable iff (rst)
                (lane_valid && !all_ready) |=>
                        (lane_valid && $stable(lane_in) && $stable(inv)))
                else $error("issue changed a stalled lane group");

endmodule

//--- hw/aessub_lane.sv
`timescale 1ns/1ps

module aessub_lane
        import aessub_types_pkg::*, aes_field_pkg::*;
(
        input  logic  clock,
        input  logic  rst,
        input  logic  in_valid,
        output logic  in_ready,
        input  byte_t in_byte,
        input  logic  inv,
        output logic  out_valid,
        output byte_t out_byte,
        input  logic  out_ready
);

        logic  full;                                    // Pipeline register occupied
        logic  take;
        byte_t sub;

        // Combinational substitution, the bulk of the area
        assign sub = inv ? sbox_inv(in_byte) : sbox_fwd(in_byte);

        assign in_ready  = !full || out_ready;
        assign take      = in_valid && in_ready;
        assign out_valid = full;

        always_ff @(posedge clock) begin
                if (rst)
                        full <= 1'b0;
                else if (take)
                        full <= 1'b1;
                else if (out_ready)
                        full <= 1'b0;
        end

        always_ff @(posedge clock) begin
                if (take)
                        out_byte <= sub;
        end

        assert property (@(posedge clock) disable iff (rst)
                (out_valid && !out_ready) |=> (out_valid && $stable(out_byte)))
                else $error("lane output changed under back-pressure");

endmodule

//--- hw/aessub_collect.sv
`timescale 1ns/1ps

module aessub_collect
        import aessub_types_pkg::*;
#(
        parameter int NUM_LANES = 4
) (
        input  logic                  clock,
        input  logic                  rst,
        input  logic [NUM_LANES-1:0]  lane_out_valid,
        input  byte_t [NUM_LANES-1:0] lane_out,
        output logic                  lane_out_ready,
        output logic                  out_valid,
        input  logic                  out_ready,
        output word_t                 result
);

        localparam int GROUPS = NUM_BYTES / NUM_LANES;

        collect_state_t state;
        group_idx_t     grp;                            // Next group expected
        lane_idx_t      slot [NUM_LANES];               // Result byte per lane
        logic           all_valid;
        logic           last_grp;
        logic           take;

        assign all_valid      = &lane_out_valid;
        assign last_grp       = (grp == group_idx_t'(GROUPS - 1));
        assign lane_out_ready = (state == FILL);        // Lanes stall while holding
        assign out_valid      = (state == HOLD);
        assign take           = all_valid && lane_out_ready;

        for (genvar k = 0; k < NUM_LANES; k++) begin : g_slot
                assign slot[k] = lane_idx_t'(grp * NUM_LANES + k);
        end

        always_ff @(posedge clock) begin
                if (rst) begin
                        state <= FILL;
                        grp   <= '0;
                end else begin
                        case (state)
                                FILL: if (take) begin
                                        if (last_grp) begin
                                                state <= HOLD;
                                                grp   <= '0;
                                        end else begin
                                                grp <= grp + 1'b1;
                                        end
                                end
                                HOLD: if (out_ready)
                                        state <= FILL;  // Consumer took the word
                                default: state <= FILL;
                        endcase
                end
        end

        // Each group lands in its own byte slots
        always_ff @(posedge clock) begin
                if (take) begin
                        for (int k = 0; k < NUM_LANES; k++)
                                result[8*slot[k] +: 8] <= lane_out[k];
                end
        end

        // Lanes are fed as one broadcast group, so they must stay in step
        assert property (@(posedge clock) disable iff (rst)
                (lane_out_valid == '0) || all_valid)
                else $error("lane valids disagree");

        assert property (@(posedge clock) disable iff (rst)
                (out_valid && !out_ready) |=> (out_valid && $stable(result)))
                else $error("result changed under back-pressure");

endmodule

//--- hw/aessub_top.sv
`timescale 1ns/1ps

module aessub_top
        import aessub_types_pkg::*;
#(
        parameter int NUM_LANES = 4                     // 1, 2 or 4
) (
        input  logic  clock,
        input  logic  rst,
        input  logic  in_valid,
        output logic  in_ready,
        input  word_t rs1,
        input  word_t rs2,
        input  logic  enc,
        input  logic  rot,
        output logic  out_valid,
        input  logic  out_ready,
        output word_t result
);

        logic                  lane_valid;              // Broadcast to all lanes
        byte_t [NUM_LANES-1:0] lane_in;
        logic                  inv;
        logic [NUM_LANES-1:0]  lane_in_ready;
        logic [NUM_LANES-1:0]  lane_out_valid;
        byte_t [NUM_LANES-1:0] lane_out;
        logic                  lane_out_ready;          // Shared by all lanes

        aessub_issue #(
                .NUM_LANES     (NUM_LANES)
        ) aessub_issue_inst (
                .clock         (clock),
                .rst           (rst),
                .in_valid      (in_valid),
                .in_ready      (in_ready),
                .rs1           (rs1),
                .rs2           (rs2),
                .enc           (enc),
                .rot           (rot),
                .lane_valid    (lane_valid),
                .lane_in       (lane_in),
                .inv           (inv),
                .lane_in_ready (lane_in_ready)
        );

        for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
                aessub_lane aessub_lane_inst (
                        .clock     (clock),
                        .rst       (rst),
                        .in_valid  (lane_valid),
                        .in_ready  (lane_in_ready[k]),
                        .in_byte   (lane_in[k]),
                        .inv       (inv),
                        .out_valid (lane_out_valid[k]),
                        .out_byte  (lane_out[k]),
                        .out_ready (lane_out_ready)
                );
        end

        aessub_collect #(
                .NUM_LANES      (NUM_LANES)
        ) aessub_collect_inst (
                .clock          (clock),
                .rst            (rst),
                .lane_out_valid (lane_out_valid),
                .lane_out       (lane_out),
                .lane_out_ready (lane_out_ready),
                .out_valid      (out_valid),
                .out_ready      (out_ready),
                .result         (result)
        );

endmodule

//--- sim/tb_aessub.sv
`timescale 1ns/1ps

module tb_aessub
        import aessub_types_pkg::*;
#(
        parameter int NUM_LANES = 4,
        parameter int SEED      = 21
);

        localparam int NUM_ROWS  = 8;
        localparam int NUM_TRIPS = 6;
        localparam int TIMEOUT   = 100;                 // Cycles allowed per wait

        typedef struct packed {
                word_t rs1;
                word_t rs2;
                logic  enc;
                logic  rot;
                word_t expected;
        } op_row_t;

        logic  clock;
        logic  rst;
        logic  in_valid;
        logic  in_ready;
        word_t rs1;
        word_t rs2;
        logic  enc;
        logic  rot;
        logic  out_valid;
        logic  out_ready;
        word_t result;

        op_row_t vectors [NUM_ROWS];
        word_t   expect_q [$];                          // Results still owed in order
        int      mismatches;
        int      timeouts;
        logic    held;                                  // Result was stalled last cycle
        word_t   held_result;

        aessub_top #(
                .NUM_LANES (NUM_LANES)
        ) aessub_top_inst (
                .clock     (clock),
                .rst       (rst),
                .in_valid  (in_valid),
                .in_ready  (in_ready),
                .rs1       (rs1),
                .rs2       (rs2),
                .enc       (enc),
                .rot       (rot),
                .out_valid (out_valid),
                .out_ready (out_ready),
                .result    (result)
        );

        initial begin
                clock = 1'b0;
                forever #2 clock = ~clock;
        end

        // Expected words built from FIPS-197 S-box values and the gather rule
        task automatic load_vectors();
                vectors[0] = '{32'ha5015a00, 32'hff3c53c3, 1'b1, 1'b0, 32'h167ced63};
                vectors[1] = '{32'h77207710, 32'h30881199, 1'b1, 1'b0, 32'h04b782ca};
                vectors[2] = '{32'h127c3463, 32'h1655ed66, 1'b0, 1'b0, 32'hff015300};
                vectors[3] = '{32'hee00ddca, 32'hb7cc82bb, 1'b0, 1'b0, 32'h20521110};
                vectors[4] = '{32'ha5015a00, 32'hff3c53c3, 1'b1, 1'b1, 32'h7ced6316};
                vectors[5] = '{32'h127c3463, 32'h1655ed66, 1'b0, 1'b1, 32'h015300ff};
                vectors[6] = '{32'h00040002, 32'h05000300, 1'b1, 1'b0, 32'h6bf27b77};
                vectors[7] = '{32'h11ff220f, 32'h0033f044, 1'b1, 1'b1, 32'h168c7663};
        endtask

        task automatic compare_word(input string what, input word_t expected, input word_t got);
                assert (got === expected) else begin
                        mismatches++;
                        $display("mismatch result %s: expected 0x%08h got 0x%08h",
                                 what, expected, got);
                end
        endtask

        task automatic check_reset_state();
                assert (out_valid === 1'b0) else begin
                        mismatches++;
                        $display("mismatch out_valid after reset: expected 0x0 got 0x%h",
                                 out_valid);
                end
                assert (in_ready === 1'b1) else begin
                        mismatches++;
                        $display("mismatch in_ready after reset: expected 0x1 got 0x%h",
                                 in_ready);
                end
        endtask

        // Called on a rising edge and returns on the transfer edge
        task automatic send_op(input word_t a, input word_t b, input logic e, input logic r);
                int waited;
                waited    = 0;
                in_valid <= 1'b1;
                rs1      <= a;
                rs2      <= b;
                enc      <= e;
                rot      <= r;
                @(negedge clock);
                while (!in_ready && waited < TIMEOUT) begin
                        @(negedge clock);
                        waited++;
                end
                assert (in_ready) else begin
                        timeouts++;
                        $display("timed out after %0d cycles waiting for in_ready", TIMEOUT);
                end
                @(posedge clock);                       // Transfer edge
        endtask

        task automatic receive_result(input bit random_ready, output word_t got, output bit ok);
                int waited;
                waited = 0;
                ok     = 1'b0;
                got    = '0;
                while (!ok && waited < TIMEOUT) begin
                        @(posedge clock);
                        if (random_ready)
                                out_ready <= 1'($urandom() % 2);
                        else
                                out_ready <= 1'b1;
                        @(negedge clock);
                        if (out_valid && out_ready) begin
                                got = result;           // Taken on the next rising edge
                                ok  = 1'b1;
                        end
                        waited++;
                end
                assert (ok) else begin
                        timeouts++;
                        $display("timed out after %0d cycles waiting for a result", TIMEOUT);
                end
        endtask

        // Result must not move while the consumer stalls it
        always @(negedge clock) begin
                if (rst) begin
                        held = 1'b0;
                end else begin
                        if (held) begin
                                assert (out_valid) else begin
                                        mismatches++;
                                        $display({"mismatch out_valid under back-pressure: ",
                                                  "expected 0x1 got 0x%h"}, out_valid);
                                end
                                assert (result === held_result) else begin
                                        mismatches++;
                                        $display({"mismatch result under back-pressure: ",
                                                  "expected 0x%08h got 0x%08h"},
                                                 held_result, result);
                                end
                        end
                        held        = out_valid && !out_ready;
                        held_result = result;
                end
        end

        initial begin
                word_t got;
                word_t fwd;
                word_t gathered;
                word_t want;
                word_t a;
                word_t b;
                bit    ok;
                rst         = 1'b1;
                in_valid    = 1'b0;
                rs1         = '0;
                rs2         = '0;
                enc         = 1'b0;
                rot         = 1'b0;
                out_ready   = 1'b0;
                held        = 1'b0;
                held_result = '0;
                mismatches  = 0;
                timeouts    = 0;
                void'($urandom(SEED));
                load_vectors();

                repeat (4) @(posedge clock);
                rst <= 1'b0;
                @(negedge clock);
                check_reset_state();

                // Directed rows one operation at a time
                for (int i = 0; i < NUM_ROWS; i++) begin
                        @(posedge clock);
                        send_op(vectors[i].rs1, vectors[i].rs2, vectors[i].enc, vectors[i].rot);
                        in_valid <= 1'b0;
                        receive_result(1'b0, got, ok);
                        if (ok)
                                compare_word($sformatf("row %0d", i), vectors[i].expected, got);
                end

                // Forward then inverse must give back the gathered bytes
                for (int i = 0; i < NUM_TRIPS; i++) begin
                        a        = $urandom();
                        b        = $urandom();
                        gathered = {b[31:24], a[23:16], b[15:8], a[7:0]};
                        @(posedge clock);
                        send_op(a, b, 1'b1, 1'b0);
                        in_valid <= 1'b0;
                        receive_result(1'b0, fwd, ok);
                        if (ok) begin
                                @(posedge clock);
                                send_op(fwd, fwd, 1'b0, 1'b0);   // Byte j lands back at in j
                                in_valid <= 1'b0;
                                receive_result(1'b0, got, ok);
                                if (ok)
                                        compare_word($sformatf("round trip %0d", i),
                                                     gathered, got);
                        end
                end

                // Back to back with a random consumer
                @(posedge clock);
                fork
                        begin
                                for (int i = 0; i < 2 * NUM_ROWS; i++) begin
                                        expect_q.push_back(vectors[i % NUM_ROWS].expected);
                                        send_op(vectors[i % NUM_ROWS].rs1,
                                                vectors[i % NUM_ROWS].rs2,
                                                vectors[i % NUM_ROWS].enc,
                                                vectors[i % NUM_ROWS].rot);
                                end
                                in_valid <= 1'b0;
                        end
                        begin
                                for (int i = 0; i < 2 * NUM_ROWS; i++) begin
                                        receive_result(1'b1, got, ok);
                                        if (ok) begin
                                                assert (expect_q.size() > 0) else begin
                                                        mismatches++;
                                                        $display("result arrived with none expected");
                                                end
                                                if (expect_q.size() > 0) begin
                                                        want = expect_q.pop_front();
                                                        compare_word($sformatf("queued op %0d", i),
                                                                     want, got);
                                                end
                                        end
                                end
                        end
                join
                @(posedge clock);
                out_ready <= 1'b1;
                repeat (2) @(posedge clock);

                $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
                if (mismatches + timeouts == 0)
                        $display("Verification passed");
                else
                        $display("Verification failed");
                $finish;
        end

endmodule

//--- build.f
hw/aessub_types_pkg.sv
hw/aes_field_pkg.sv
hw/aessub_issue.sv
hw/aessub_lane.sv
hw/aessub_collect.sv
hw/aessub_top.sv
sim/tb_aessub.sv

//--- Makefile
# Verilator build and run for the AES SubBytes unit

VERILATOR ?= verilator
TOP       ?= tb_aessub
RTL_TOP   ?= aessub_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
NUM_LANES ?= 4
SEED      ?= 21
JOBS      ?= 0

VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PARAMS  = -GNUM_LANES=$(NUM_LANES) -GSEED=$(SEED)

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) $(PARAMS) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(TOP) $(PARAMS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
